// ==== rtl/spi_pkg.sv ====
package spi_pkg;

    // Byte offsets of the APB registers
    typedef enum logic [3:0] {
        REG_CTRL   = 4'd0,
        REG_STATUS = 4'd4,
        REG_TXDATA = 4'd8,
        REG_RXDATA = 4'd12
    } spi_reg_addr_t;

    // Bit positions inside REG_CTRL
    localparam int CTRL_ENABLE_BIT    = 0;
    localparam int CTRL_LSB_FIRST_BIT = 1;
    localparam int CTRL_LENGTH_LSB    = 8;
    localparam int CTRL_LENGTH_WIDTH  = 5;

    // Bit positions inside REG_STATUS
    localparam int STATUS_BUSY_BIT     = 0;
    localparam int STATUS_TX_FULL_BIT  = 1;
    localparam int STATUS_RX_EMPTY_BIT = 2;

    // One queued transfer; the control fields travel with the word
    // so later CTRL writes leave queued words untouched
    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  length_minus_one;
        logic        lsb_first;
    } spi_tx_entry_t;

    // Transfer engine states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_SHIFT,
        ST_DONE
    } spi_state_t;

endpackage

// ==== rtl/spi_word_fifo.sv ====
module spi_word_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             full,
    output logic             empty
);
    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0]       storage [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   write_ptr;
    logic [PTR_WIDTH-1:0]   read_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    // A push into a full FIFO or a pop from an empty one is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == COUNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Show-ahead output
    assign head = storage[read_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            storage[write_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (do_push) begin
                write_ptr <= (write_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (do_pop) begin
                read_ptr <= (read_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/spi_shift_register.sv ====
module spi_shift_register import spi_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          load,
    input  spi_tx_entry_t load_entry,
    input  logic          shift_out_edge,
    input  logic          sample_edge,
    input  logic          miso,
    output logic          mosi,
    output logic [31:0]   received
);
    logic [31:0] shift_reg;
    logic [4:0]  length_minus_one;
    logic        lsb_first;
    logic [31:0] shifted;
    logic [31:0] length_mask;

    // Transmit bits leave from one end while received bits enter at the other,
    // so after length_minus_one + 1 samples the word is fully replaced
    always_comb begin
        if (lsb_first) begin
            shifted = shift_reg >> 1;
            shifted[length_minus_one] = miso;
        end else begin
            shifted = shift_reg << 1;
            shifted[0] = miso;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            shift_reg        <= load_entry.data;
            length_minus_one <= load_entry.length_minus_one;
            lsb_first        <= load_entry.lsb_first;
        end else if (sample_edge) begin
            shift_reg <= shifted;
        end
    end

    // The first bit goes out with the load, the rest on each falling edge
    always_ff @(posedge clock) begin
        if (!reset) begin
            mosi <= 1'b0;
        end else if (load) begin
            if (load_entry.lsb_first) begin
                mosi <= load_entry.data[0];
            end else begin
                mosi <= load_entry.data[load_entry.length_minus_one];
            end
        end else if (shift_out_edge) begin
            if (lsb_first) begin
                mosi <= shift_reg[0];
            end else begin
                mosi <= shift_reg[length_minus_one];
            end
        end
    end

    // Upper bits above the transfer length still hold leftover transmit data
    assign length_mask = 32'hffff_ffff >> (5'd31 - length_minus_one);
    assign received    = shift_reg & length_mask;

endmodule

// ==== rtl/spi_transfer_engine.sv ====
module spi_transfer_engine import spi_pkg::*; #(
    parameter int CLOCK_DIVIDER = 2
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          enable,
    input  spi_tx_entry_t tx_head,
    input  logic          tx_empty,
    output logic          tx_pop,
    input  logic          rx_full,
    output logic          rx_push,
    output logic [31:0]   rx_word,
    output logic          busy,
    output logic          sclk,
    output logic          cs_n,
    output logic          mosi,
    input  logic          miso
);
    localparam int DIV_WIDTH = (CLOCK_DIVIDER > 1) ? $clog2(CLOCK_DIVIDER) : 1;

    spi_state_t           state;
    logic [DIV_WIDTH-1:0] div_count;
    logic [4:0]           bit_count;
    logic [4:0]           length_minus_one;
    logic                 half_end;
    logic                 last_bit;
    logic                 sample_edge;
    logic                 falling_edge;
    logic                 shift_out_edge;

    // A new transfer starts only when its result has room in the receive FIFO
    assign tx_pop  = (state == ST_IDLE) && enable && !tx_empty && !rx_full;
    assign rx_push = (state == ST_DONE);
    assign busy    = (state != ST_IDLE);

    assign half_end       = (div_count == DIV_WIDTH'(CLOCK_DIVIDER - 1));
    assign last_bit       = (bit_count == length_minus_one);
    assign sample_edge    = half_end && ((state == ST_SETUP) || (state == ST_SHIFT && !sclk));
    assign falling_edge   = half_end && (state == ST_SHIFT) && sclk;
    // No new bit is presented after the final falling edge
    assign shift_out_edge = falling_edge && !last_bit;

    always_ff @(posedge clock) begin
        if (tx_pop) begin
            length_minus_one <= tx_head.length_minus_one;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= ST_IDLE;
            div_count <= '0;
            bit_count <= '0;
            sclk      <= 1'b0;
            cs_n      <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    div_count <= '0;
                    bit_count <= '0;
                    if (tx_pop) begin
                        cs_n  <= 1'b0;
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    div_count <= half_end ? '0 : div_count + 1'b1;
                    if (half_end) begin
                        sclk  <= 1'b1;
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    div_count <= half_end ? '0 : div_count + 1'b1;
                    if (half_end) begin
                        sclk <= !sclk;
                    end
                    if (falling_edge) begin
                        if (last_bit) begin
                            state <= ST_DONE;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    cs_n  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    spi_shift_register shift_register_i (
        .clock          (clock),
        .reset          (reset),
        .load           (tx_pop),
        .load_entry     (tx_head),
        .shift_out_edge (shift_out_edge),
        .sample_edge    (sample_edge),
        .miso           (miso),
        .mosi           (mosi),
        .received       (rx_word)
    );

endmodule

// ==== rtl/apb_spi_regs.sv ====
module apb_spi_regs import spi_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [3:0]    paddr,
    input  logic [31:0]   pwdata,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    output logic          enable,
    output logic          tx_push,
    output spi_tx_entry_t tx_entry,
    input  logic          tx_full,
    output logic          rx_pop,
    input  logic [31:0]   rx_head,
    input  logic          rx_empty,
    input  logic          busy
);
    spi_reg_addr_t reg_addr;
    logic          access;
    logic          lsb_first;
    logic [4:0]    length_minus_one;
    logic [31:0]   ctrl_word;
    logic [31:0]   status_word;

    // Every access finishes in its first access phase
    assign pready   = 1'b1;
    assign access   = psel && penable;
    assign reg_addr = spi_reg_addr_t'(paddr);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_ENABLE_BIT] = enable;
        ctrl_word[CTRL_LSB_FIRST_BIT] = lsb_first;
        ctrl_word[CTRL_LENGTH_LSB +: CTRL_LENGTH_WIDTH] = length_minus_one;
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_BUSY_BIT] = busy;
        status_word[STATUS_TX_FULL_BIT] = tx_full;
        status_word[STATUS_RX_EMPTY_BIT] = rx_empty;
    end

    // The current control fields are attached to each transmit word
    assign tx_entry.data             = pwdata;
    assign tx_entry.length_minus_one = length_minus_one;
    assign tx_entry.lsb_first        = lsb_first;

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        tx_push = 1'b0;
        rx_pop  = 1'b0;
        if (access) begin
            case (reg_addr)
                REG_CTRL: begin
                    prdata = pwrite ? '0 : ctrl_word;
                end
                REG_STATUS: begin
                    prdata = pwrite ? '0 : status_word;
                end
                REG_TXDATA: begin
                    if (pwrite) begin
                        tx_push = !tx_full;
                        pslverr = tx_full;
                    end
                end
                REG_RXDATA: begin
                    if (!pwrite) begin
                        // An empty FIFO answers with zero and an error
                        rx_pop  = !rx_empty;
                        pslverr = rx_empty;
                        prdata  = rx_empty ? '0 : rx_head;
                    end
                end
                default: begin
                    pslverr = 1'b1;
                end
            endcase
        end
    end

    // Reset selects full 32-bit transfers, MSB first, engine stopped
    always_ff @(posedge clock) begin
        if (!reset) begin
            enable           <= 1'b0;
            lsb_first        <= 1'b0;
            length_minus_one <= 5'd31;
        end else if (access && pwrite && reg_addr == REG_CTRL) begin
            enable           <= pwdata[CTRL_ENABLE_BIT];
            lsb_first        <= pwdata[CTRL_LSB_FIRST_BIT];
            length_minus_one <= pwdata[CTRL_LENGTH_LSB +: CTRL_LENGTH_WIDTH];
        end
    end

endmodule

// ==== rtl/apb_spi_master.sv ====
module apb_spi_master import spi_pkg::*; #(
    parameter int CLOCK_DIVIDER = 2,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        sclk,
    output logic        cs_n,
    output logic        mosi,
    input  logic        miso
);
    spi_tx_entry_t tx_entry;
    spi_tx_entry_t tx_head;
    logic          tx_push;
    logic          tx_pop;
    logic          tx_full;
    logic          tx_empty;
    logic [31:0]   rx_word;
    logic [31:0]   rx_head;
    logic          rx_push;
    logic          rx_pop;
    logic          rx_full;
    logic          rx_empty;
    logic          enable;
    logic          busy;

    apb_spi_regs regs_i (
        .clock    (clock),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .enable   (enable),
        .tx_push  (tx_push),
        .tx_entry (tx_entry),
        .tx_full  (tx_full),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_empty (rx_empty),
        .busy     (busy)
    );

    // Transmit queue carries whole entries, receive queue plain words
    spi_word_fifo #(
        .WIDTH      ($bits(spi_tx_entry_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_fifo_i (
        .clock     (clock),
        .reset     (reset),
        .push      (tx_push),
        .push_data (tx_entry),
        .pop       (tx_pop),
        .head      (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    spi_word_fifo #(
        .WIDTH      (32),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_fifo_i (
        .clock     (clock),
        .reset     (reset),
        .push      (rx_push),
        .push_data (rx_word),
        .pop       (rx_pop),
        .head      (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    spi_transfer_engine #(
        .CLOCK_DIVIDER (CLOCK_DIVIDER)
    ) engine_i (
        .clock    (clock),
        .reset    (reset),
        .enable   (enable),
        .tx_head  (tx_head),
        .tx_empty (tx_empty),
        .tx_pop   (tx_pop),
        .rx_full  (rx_full),
        .rx_push  (rx_push),
        .rx_word  (rx_word),
        .busy     (busy),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

// ==== tests/apb_spi_master_checker.sv ====
module apb_spi_master_checker import spi_pkg::*; (
    input logic       clock,
    input logic       reset,
    input logic       psel,
    input logic       penable,
    input logic       pslverr,
    input logic       sclk,
    input logic       cs_n,
    input logic       mosi,
    input logic       rx_push,
    input logic       rx_full,
    input spi_state_t engine_state
);
    pslverr_in_access: assert property (@(posedge clock) disable iff (!reset)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an APB access phase");

    // Mode 0 keeps the clock idle low whenever the slave is deselected
    sclk_idle_low: assert property (@(posedge clock) disable iff (!reset)
        cs_n |-> !sclk)
        else $error("sclk high while cs_n is high");

    rx_no_overflow: assert property (@(posedge clock) disable iff (!reset)
        !(rx_push && rx_full))
        else $error("rx_push while the receive FIFO is full");

    mosi_stable_high: assert property (@(posedge clock) disable iff (!reset)
        sclk |-> $stable(mosi))
        else $error("mosi changed while sclk is high");

    idle_deselected: assert property (@(posedge clock) disable iff (!reset)
        (engine_state == ST_IDLE) |-> cs_n)
        else $error("cs_n low while the engine is idle");

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2,
    parameter int DRIVE_DELAY  = 2
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset is released with the same offset as the other stimulus
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b1;
    end

endmodule

// ==== tests/apb_spi_master_tb.sv ====
module apb_spi_master_tb import spi_pkg::*; ();
    localparam int CLOCK_DIVIDER   = 2;
    localparam int FIFO_DEPTH      = 4;
    localparam int CLOCK_PERIOD    = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int SAMPLE_DELAY    = 8;
    localparam int TRANSFER_CYCLES = 32 * 2 * CLOCK_DIVIDER + 20;
    localparam int WATCHDOG_TIME   = 40 * TRANSFER_CYCLES * CLOCK_PERIOD;

    // What the slave model saw during one chip select window
    typedef struct packed {
        logic [31:0] slave_word;
        logic [31:0] mosi_bits;
        logic [5:0]  bit_count;
    } slave_capture_t;

    logic           clock;
    logic           reset;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [3:0]     paddr;
    logic [31:0]    pwdata;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;
    logic           sclk;
    logic           cs_n;
    logic           mosi;
    logic           miso;
    integer         seed = 95;
    int             error_count = 0;
    int             check_count = 0;
    int             capture_count = 0;
    logic           cur_lsb = 1'b0;
    logic [4:0]     cur_len_m1 = 5'd31;
    spi_tx_entry_t  sent_q[$];
    slave_capture_t capture_q[$];
    logic [31:0]    expected_rx_q[$];
    logic [31:0]    popped_q[$];

    tb_clock_gen #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (2),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    apb_spi_master #(
        .CLOCK_DIVIDER (CLOCK_DIVIDER),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) dut_i (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .mosi    (mosi),
        .miso    (miso)
    );

    bind apb_spi_master apb_spi_master_checker checker_i (
        .clock        (clock),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pslverr      (pslverr),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .rx_push      (rx_push),
        .rx_full      (rx_full),
        .engine_state (engine_i.state)
    );

    // Step k of the slave word lands at bit k or at bit length-1-k
    function automatic logic [31:0] expected_rx(input logic [31:0] slave_word,
                                                input logic [4:0] len_m1,
                                                input logic lsb_first);
        logic [31:0] result;
        int          length;
        length = int'(len_m1) + 1;
        result = '0;
        for (int k = 0; k < length; k++) begin
            if (lsb_first) begin
                result[k] = slave_word[31 - k];
            end else begin
                result[length - 1 - k] = slave_word[31 - k];
            end
        end
        return result;
    endfunction

    // Serial order of the master with the first bit at the top of the length
    function automatic logic [31:0] expected_mosi(input spi_tx_entry_t entry);
        logic [31:0] result;
        int          length;
        length = int'(entry.length_minus_one) + 1;
        result = '0;
        for (int k = 0; k < length; k++) begin
            if (entry.lsb_first) begin
                result[length - 1 - k] = entry.data[k];
            end else begin
                result[length - 1 - k] = entry.data[length - 1 - k];
            end
        end
        return result;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR at %0t: %s: got 0x%h, expected 0x%h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge clock);
        #DRIVE_DELAY;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clock);
        #DRIVE_DELAY;
        penable = 1'b1;
        #SAMPLE_DELAY;
        err = pslverr;
        check_value(32'(pready), 32'd1, "pready in write access phase");
        @(posedge clock);
        #DRIVE_DELAY;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge clock);
        #DRIVE_DELAY;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clock);
        #DRIVE_DELAY;
        penable = 1'b1;
        #SAMPLE_DELAY;
        data = prdata;
        err = pslverr;
        check_value(32'(pready), 32'd1, "pready in read access phase");
        @(posedge clock);
        #DRIVE_DELAY;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_ctrl(input logic en, input logic lsb, input logic [4:0] len_m1);
        logic [31:0] word;
        logic [31:0] data;
        logic        err;
        word = '0;
        word[CTRL_ENABLE_BIT] = en;
        word[CTRL_LSB_FIRST_BIT] = lsb;
        word[CTRL_LENGTH_LSB +: CTRL_LENGTH_WIDTH] = len_m1;
        apb_write(REG_CTRL, word, err);
        check_value(32'(err), 32'd0, "pslverr on CTRL write");
        apb_read(REG_CTRL, data, err);
        check_value(data, word, "CTRL readback");
        cur_lsb = lsb;
        cur_len_m1 = len_m1;
    endtask

    task automatic wait_status(input int bit_index, input logic value, input string what);
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(REG_STATUS, status, err);
        while (status[bit_index] !== value && polls < TRANSFER_CYCLES) begin
            apb_read(REG_STATUS, status, err);
            polls++;
        end
        if (status[bit_index] !== value) begin
            $display("Timed out waiting for %s", what);
            error_count++;
        end
    endtask

    // The entry records the control settings in force at this write
    task automatic queue_word(input logic [31:0] data);
        spi_tx_entry_t entry;
        logic          err;
        wait_status(STATUS_TX_FULL_BIT, 1'b0, "room in the transmit FIFO");
        apb_write(REG_TXDATA, data, err);
        check_value(32'(err), 32'd0, "pslverr on TXDATA write");
        entry.data = data;
        entry.length_minus_one = cur_len_m1;
        entry.lsb_first = cur_lsb;
        sent_q.push_back(entry);
    endtask

    task automatic receive_word();
        logic [31:0] data;
        logic        err;
        wait_status(STATUS_RX_EMPTY_BIT, 1'b0, "a received word");
        apb_read(REG_RXDATA, data, err);
        check_value(32'(err), 32'd0, "pslverr on RXDATA read");
        popped_q.push_back(data);
    endtask

    task automatic wait_captures(input int target);
        int cycles;
        cycles = 0;
        while (capture_count < target && cycles < FIFO_DEPTH * TRANSFER_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        if (capture_count < target) begin
            $display("Timed out waiting for SPI transfers to finish");
            error_count++;
        end
    endtask

    // SPI slave in mode 0 moves miso on falling sclk and takes mosi on rising sclk
    initial begin : slave_model
        logic [31:0]    slave_word;
        logic [31:0]    mosi_bits;
        int             step;
        int             bit_count;
        slave_capture_t capture;
        miso = 1'b0;
        forever begin
            @(negedge cs_n);
            slave_word = $random(seed);
            mosi_bits = '0;
            step = 0;
            bit_count = 0;
            miso = slave_word[31];
            while (cs_n === 1'b0) begin
                @(posedge sclk or posedge cs_n);
                if (cs_n === 1'b0) begin
                    mosi_bits = {mosi_bits[30:0], mosi};
                    bit_count++;
                    @(negedge sclk);
                    step++;
                    miso = (step < 32) ? slave_word[31 - step] : 1'b0;
                end
            end
            capture.slave_word = slave_word;
            capture.mosi_bits = mosi_bits;
            capture.bit_count = 6'(bit_count);
            capture_q.push_back(capture);
            capture_count++;
        end
    end

    always @(posedge clock) begin : compare_results
        spi_tx_entry_t  entry;
        slave_capture_t capture;
        while (capture_q.size() > 0 && sent_q.size() > 0) begin
            capture = capture_q.pop_front();
            entry = sent_q.pop_front();
            check_value(32'(capture.bit_count), 32'(entry.length_minus_one) + 32'd1,
                        "SPI bit count");
            check_value(capture.mosi_bits, expected_mosi(entry), "mosi sequence");
            expected_rx_q.push_back(expected_rx(capture.slave_word, entry.length_minus_one,
                                                entry.lsb_first));
        end
        while (popped_q.size() > 0 && expected_rx_q.size() > 0) begin
            check_value(popped_q.pop_front(), expected_rx_q.pop_front(), "received word");
        end
    end

    initial begin : watchdog
        #WATCHDOG_TIME;
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : run_tests
        logic [31:0] data;
        logic [31:0] rand_word;
        logic        err;
        logic        cs_low_seen;
        int          base;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        wait (reset === 1'b1);

        // Reset state of the pins, STATUS and an empty receive FIFO
        check_value(32'(cs_n), 32'd1, "cs_n after reset");
        check_value(32'(sclk), 32'd0, "sclk after reset");
        check_value(32'(mosi), 32'd0, "mosi after reset");
        apb_read(REG_STATUS, data, err);
        check_value(data, 32'd1 << STATUS_RX_EMPTY_BIT, "STATUS after reset");
        check_value(32'(err), 32'd0, "pslverr on STATUS read");
        apb_read(REG_RXDATA, data, err);
        check_value(data, 32'd0, "RXDATA read while empty");
        check_value(32'(err), 32'd1, "pslverr on empty RXDATA read");
        apb_read(4'd2, data, err);
        check_value(32'(err), 32'd1, "pslverr on undefined offset");

        // Full 32-bit words with the MSB first
        set_ctrl(1'b1, 1'b0, 5'd31);
        repeat (4) begin
            rand_word = $random(seed);
            queue_word(rand_word);
        end
        repeat (4) receive_word();

        // LSB first with lengths 1, 32 and then random
        for (int i = 0; i < 8; i++) begin
            rand_word = $random(seed);
            if (i == 0) begin
                rand_word[4:0] = 5'd0;
            end else if (i == 1) begin
                rand_word[4:0] = 5'd31;
            end
            set_ctrl(1'b1, 1'b1, rand_word[4:0]);
            rand_word = $random(seed);
            queue_word(rand_word);
            receive_word();
        end

        // Fill the transmit FIFO with the engine stopped
        set_ctrl(1'b0, 1'b0, 5'd15);
        repeat (FIFO_DEPTH) begin
            rand_word = $random(seed);
            queue_word(rand_word);
        end
        apb_write(REG_TXDATA, 32'hdead_beef, err);
        check_value(32'(err), 32'd1, "pslverr on TXDATA write while full");
        apb_read(REG_STATUS, data, err);
        check_value(32'(data[STATUS_TX_FULL_BIT]), 32'd1, "STATUS tx_full");
        set_ctrl(1'b1, 1'b0, 5'd15);
        repeat (FIFO_DEPTH) receive_word();

        // Each queued word keeps the settings of its own write
        set_ctrl(1'b0, 1'b0, 5'd7);
        queue_word($random(seed));
        set_ctrl(1'b0, 1'b1, 5'd16);
        queue_word($random(seed));
        set_ctrl(1'b0, 1'b0, 5'd23);
        queue_word($random(seed));
        set_ctrl(1'b1, 1'b1, 5'd4);
        repeat (3) receive_word();

        // More words than the receive FIFO holds and no reads for a while
        set_ctrl(1'b1, 1'b1, 5'd9);
        base = capture_count;
        repeat (FIFO_DEPTH + 2) begin
            rand_word = $random(seed);
            queue_word(rand_word);
        end
        wait_captures(base + FIFO_DEPTH);
        cs_low_seen = 1'b0;
        repeat (TRANSFER_CYCLES) begin
            @(posedge clock);
            #SAMPLE_DELAY;
            if (cs_n !== 1'b1) begin
                cs_low_seen = 1'b1;
            end
        end
        check_value(32'(cs_low_seen), 32'd0, "cs_n low while the receive FIFO is full");
        check_value(capture_count, base + FIFO_DEPTH, "transfers while the receive FIFO is full");
        repeat (FIFO_DEPTH + 2) receive_word();

        repeat (4) @(posedge clock);
        if (sent_q.size() != 0 || capture_q.size() != 0 || expected_rx_q.size() != 0 ||
            popped_q.size() != 0) begin
            $display("Some transfers or received words were left unmatched at the end");
            error_count++;
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== apb_spi_master.f ====
rtl/spi_pkg.sv
rtl/spi_word_fifo.sv
rtl/spi_shift_register.sv
rtl/spi_transfer_engine.sv
rtl/apb_spi_regs.sv
rtl/apb_spi_master.sv
tests/apb_spi_master_checker.sv
tests/tb_clock_gen.sv
tests/apb_spi_master_tb.sv
